/* logic/cpuPkg.sv */
package cpuPkg;

  // Datapath and register index widths
  localparam int WordWidth = 32;
  localparam int RegNumWidth = 4;
  localparam int RegCount = 16;

  typedef logic [WordWidth-1:0] wordT;
  typedef logic [RegNumWidth-1:0] regNumT;
  typedef logic [7:0] opcodeT;

  // Instruction word fields
  localparam int OpMsb = 31;
  localparam int OpLsb = 24;
  localparam int RdMsb = 23;
  localparam int RsMsb = 19;
  localparam int RtMsb = 15;
  localparam int ImmWidth = 16;

  // First fetch address and instruction size in bytes
  localparam wordT StartPc = 32'h0000_0400;
  localparam wordT PcStep = 32'd4;

  // Logic group, odd codes take the immediate
  localparam opcodeT OpAnd = 8'h00;
  localparam opcodeT OpAndi = 8'h01;
  localparam opcodeT OpNand = 8'h02;
  localparam opcodeT OpNandi = 8'h03;
  localparam opcodeT OpOr = 8'h04;
  localparam opcodeT OpOri = 8'h05;
  localparam opcodeT OpNor = 8'h06;
  localparam opcodeT OpNori = 8'h07;
  localparam opcodeT OpXor = 8'h08;
  localparam opcodeT OpXori = 8'h09;
  // Compare group
  localparam opcodeT OpEq = 8'h10;
  localparam opcodeT OpEqi = 8'h11;
  localparam opcodeT OpNe = 8'h12;
  localparam opcodeT OpNei = 8'h13;
  localparam opcodeT OpLt = 8'h14;
  localparam opcodeT OpLti = 8'h15;
  localparam opcodeT OpLe = 8'h16;
  localparam opcodeT OpLei = 8'h17;
  // Arithmetic group
  localparam opcodeT OpAdd = 8'h20;
  localparam opcodeT OpAddi = 8'h21;
  localparam opcodeT OpSub = 8'h22;
  localparam opcodeT OpSubi = 8'h23;
  // Memory and control flow
  localparam opcodeT OpLw = 8'h40;
  localparam opcodeT OpSw = 8'h60;
  localparam opcodeT OpJrl = 8'h80;
  localparam opcodeT OpBeq = 8'h90;
  localparam opcodeT OpBeqz = 8'h91;
  localparam opcodeT OpBne = 8'h92;
  localparam opcodeT OpBnez = 8'h93;

  typedef enum logic [1:0] {AluLogic = 2'd0, AluArith = 2'd1, AluCompare = 2'd2} aluOpT;
  typedef enum logic [1:0] {LogicAnd = 2'd0, LogicOr = 2'd1, LogicXor = 2'd2} logicOpT;

  // Three-cycle fetch slot
  typedef enum logic [1:0] {IssueSlot = 2'd0, BubbleOne = 2'd1, BubbleTwo = 2'd2} issueStateT;

  // Memory and writeback bits carried from A into M
  localparam int StageMemWrite = 0;
  localparam int StageMemRead = 1;
  localparam int StageRegWrite = 2;
  localparam int StageSavePc = 3;
  localparam int StageDestLsb = 4;
  localparam int StageCtrlWidth = StageDestLsb + RegNumWidth;

  typedef logic [StageCtrlWidth-1:0] stageCtrlT;

endpackage

/* logic/decodeIf.sv */
`timescale 1ns/1ps

interface decodeIf;
  // ALU function select
  cpuPkg::aluOpT aluOp;
  cpuPkg::logicOpT logicOp;
  logic logicInvert, subtract;
  logic cmpEq, cmpLt, cmpInvert;
  // Second operand source
  logic useImm, zeroImm;
  // Control flow
  logic isBranch, isJump, savePc;
  // Memory and register write
  logic memWrite, memRead;
  logic regWrite;
  cpuPkg::regNumT destReg;
  cpuPkg::wordT immValue;

  modport decoder (
    output aluOp, logicOp, logicInvert, subtract, cmpEq, cmpLt, cmpInvert,
    output useImm, zeroImm, isBranch, isJump, savePc,
    output memWrite, memRead, regWrite, destReg, immValue
  );

  modport execute (
    input aluOp, logicOp, logicInvert, subtract, cmpEq, cmpLt, cmpInvert,
    input useImm, zeroImm, isBranch, isJump, savePc,
    input memWrite, memRead, regWrite, destReg, immValue
  );

endinterface

/* logic/fetchUnit.sv */
`timescale 1ns/1ps

module fetchUnit (
  input  logic         CLK,
  input  logic         reset,
  input  logic         takeRedirect,
  input  cpuPkg::wordT redirectPc,
  output cpuPkg::wordT imemAddr,
  output logic         issueValid
);

  cpuPkg::wordT pc;
  cpuPkg::wordT nextPc;
  cpuPkg::issueStateT issueState;

  // Redirect is only ever raised while the slot sits in BubbleTwo
  assign nextPc = takeRedirect ? redirectPc : pc + cpuPkg::PcStep;

  always_ff @(posedge CLK) begin
    if (reset) begin
      pc <= cpuPkg::StartPc;
      issueState <= cpuPkg::IssueSlot;
      issueValid <= 1'b0;
    end else begin
      // Word sampled at this edge reaches the decoder next cycle
      issueValid <= (issueState == cpuPkg::IssueSlot);
      case (issueState)
        cpuPkg::IssueSlot: begin
          issueState <= cpuPkg::BubbleOne;
        end
        cpuPkg::BubbleOne: begin
          issueState <= cpuPkg::BubbleTwo;
        end
        default: begin
          // A has resolved the previous instruction
          // PC loads as the issue phase begins
          issueState <= cpuPkg::IssueSlot;
          pc <= nextPc;
        end
      endcase
    end
  end

  // PC holds still for the whole slot so R and A can still see it
  assign imemAddr = pc;

endmodule

/* logic/instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder (
  input  cpuPkg::wordT   instrWord,
  input  logic           issueValid,
  output cpuPkg::regNumT readReg1,
  output cpuPkg::regNumT readReg2,
  decodeIf.decoder       ctrl
);

  cpuPkg::opcodeT opcode;
  cpuPkg::regNumT rdField, rsField, rtField;
  cpuPkg::wordT immExt;
  logic wordValid, aluForm, zeroBranch;

  assign opcode = instrWord[cpuPkg::OpMsb:cpuPkg::OpLsb];
  assign rdField = instrWord[cpuPkg::RdMsb -: cpuPkg::RegNumWidth];
  assign rsField = instrWord[cpuPkg::RsMsb -: cpuPkg::RegNumWidth];
  assign rtField = instrWord[cpuPkg::RtMsb -: cpuPkg::RegNumWidth];
  assign immExt = {{(cpuPkg::WordWidth - cpuPkg::ImmWidth){instrWord[cpuPkg::ImmWidth-1]}},
                   instrWord[cpuPkg::ImmWidth-1:0]};

  // All-zero word acts as a no-op
  assign wordValid = issueValid && (instrWord != '0);

  // Logic, compare and arithmetic forms all write rd
  assign aluForm = opcode inside {
    cpuPkg::OpAnd, cpuPkg::OpAndi, cpuPkg::OpNand, cpuPkg::OpNandi, cpuPkg::OpOr,
    cpuPkg::OpOri, cpuPkg::OpNor, cpuPkg::OpNori, cpuPkg::OpXor, cpuPkg::OpXori,
    cpuPkg::OpEq, cpuPkg::OpEqi, cpuPkg::OpNe, cpuPkg::OpNei, cpuPkg::OpLt,
    cpuPkg::OpLti, cpuPkg::OpLe, cpuPkg::OpLei, cpuPkg::OpAdd, cpuPkg::OpAddi,
    cpuPkg::OpSub, cpuPkg::OpSubi};
  assign zeroBranch = (opcode == cpuPkg::OpBeqz) || (opcode == cpuPkg::OpBnez);

  // Zero-compare branches test rd, everything else reads rs first
  assign readReg1 = zeroBranch ? rdField : rsField;
  // Stores and two-register branches take rd as the second source
  assign readReg2 = (aluForm && !opcode[0]) ? rtField : rdField;

  always_comb begin
    ctrl.aluOp = cpuPkg::AluLogic;
    ctrl.logicOp = cpuPkg::LogicAnd;
    {ctrl.logicInvert, ctrl.subtract, ctrl.cmpEq, ctrl.cmpLt, ctrl.cmpInvert} = '0;
    {ctrl.useImm, ctrl.zeroImm, ctrl.isBranch, ctrl.isJump, ctrl.savePc} = '0;
    {ctrl.memWrite, ctrl.memRead, ctrl.regWrite} = '0;
    ctrl.destReg = '0;
    ctrl.immValue = '0;
    if (wordValid) begin
      ctrl.destReg = rdField;
      ctrl.immValue = immExt;
      ctrl.regWrite = aluForm;
      // Odd opcode selects the immediate form
      ctrl.useImm = aluForm && opcode[0];
      // Opcode bit 1 marks the inverted variant inside each pair
      case (opcode)
        cpuPkg::OpAnd, cpuPkg::OpAndi, cpuPkg::OpNand, cpuPkg::OpNandi: begin
          ctrl.logicInvert = opcode[1];
        end
        cpuPkg::OpOr, cpuPkg::OpOri, cpuPkg::OpNor, cpuPkg::OpNori: begin
          ctrl.logicOp = cpuPkg::LogicOr;
          ctrl.logicInvert = opcode[1];
        end
        cpuPkg::OpXor, cpuPkg::OpXori: begin
          ctrl.logicOp = cpuPkg::LogicXor;
        end
        cpuPkg::OpEq, cpuPkg::OpEqi, cpuPkg::OpNe, cpuPkg::OpNei: begin
          ctrl.aluOp = cpuPkg::AluCompare;
          ctrl.cmpEq = 1'b1;
          ctrl.cmpInvert = opcode[1];
        end
        cpuPkg::OpLt, cpuPkg::OpLti, cpuPkg::OpLe, cpuPkg::OpLei: begin
          // Less-than needs the difference for its sign bit
          ctrl.aluOp = cpuPkg::AluCompare;
          ctrl.subtract = 1'b1;
          ctrl.cmpLt = 1'b1;
          ctrl.cmpEq = opcode[1];
        end
        cpuPkg::OpAdd, cpuPkg::OpAddi, cpuPkg::OpSub, cpuPkg::OpSubi: begin
          ctrl.aluOp = cpuPkg::AluArith;
          ctrl.subtract = opcode[1];
        end
        cpuPkg::OpLw: begin
          ctrl.aluOp = cpuPkg::AluArith;
          ctrl.useImm = 1'b1;
          ctrl.memRead = 1'b1;
          ctrl.regWrite = 1'b1;
        end
        cpuPkg::OpSw: begin
          ctrl.aluOp = cpuPkg::AluArith;
          ctrl.useImm = 1'b1;
          ctrl.memWrite = 1'b1;
        end
        cpuPkg::OpJrl: begin
          // Target is rs plus word offset, rd gets the return address
          ctrl.aluOp = cpuPkg::AluArith;
          ctrl.useImm = 1'b1;
          ctrl.isJump = 1'b1;
          ctrl.savePc = 1'b1;
          ctrl.regWrite = 1'b1;
          ctrl.immValue = immExt << 2;
        end
        cpuPkg::OpBeq, cpuPkg::OpBeqz, cpuPkg::OpBne, cpuPkg::OpBnez: begin
          // Zero forms compare against a zero operand
          ctrl.aluOp = cpuPkg::AluCompare;
          ctrl.cmpEq = 1'b1;
          ctrl.cmpInvert = opcode[1];
          ctrl.useImm = opcode[0];
          ctrl.zeroImm = opcode[0];
          ctrl.isBranch = 1'b1;
          ctrl.immValue = immExt << 2;
        end
        default: ;
      endcase
    end
  end

endmodule

/* logic/regFile.sv */
`timescale 1ns/1ps

module regFile (
  input  logic           CLK,
  input  cpuPkg::regNumT readReg1,
  input  cpuPkg::regNumT readReg2,
  output cpuPkg::wordT   readData1,
  output cpuPkg::wordT   readData2,
  input  logic           regWe,
  input  cpuPkg::regNumT regWaddr,
  input  cpuPkg::wordT   regWdata
);

  cpuPkg::wordT regs [cpuPkg::RegCount];

  // Write from W at the end of the cycle
  always_ff @(posedge CLK) begin
    if (regWe) begin
      regs[regWaddr] <= regWdata;
    end
  end

  // Same-cycle write is passed straight to the reader
  // so R sees the result that W is retiring
  assign readData1 = (regWe && (regWaddr == readReg1)) ? regWdata : regs[readReg1];
  assign readData2 = (regWe && (regWaddr == readReg2)) ? regWdata : regs[readReg2];

endmodule

/* logic/alu.sv */
`timescale 1ns/1ps

module alu (
  input  cpuPkg::wordT    operandA,
  input  cpuPkg::wordT    operandB,
  input  cpuPkg::aluOpT   aluOp,
  input  cpuPkg::logicOpT logicOp,
  input  logic            logicInvert,
  input  logic            subtract,
  input  logic            cmpEq,
  input  logic            cmpLt,
  input  logic            cmpInvert,
  output cpuPkg::wordT    result
);

  cpuPkg::wordT logicRaw;
  cpuPkg::wordT sumOut;
  logic cmpRaw;

  always_comb begin
    case (logicOp)
      cpuPkg::LogicAnd: logicRaw = operandA & operandB;
      cpuPkg::LogicOr: logicRaw = operandA | operandB;
      cpuPkg::LogicXor: logicRaw = operandA ^ operandB;
      default: logicRaw = '0;
    endcase
  end

  // Shared adder, subtract as A plus inverted B plus one
  assign sumOut = operandA + (subtract ? ~operandB : operandB) + {31'd0, subtract};

  // LE sets both cmpEq and cmpLt
  // Sign of A-B stands in for less-than
  assign cmpRaw = (cmpEq && (operandA == operandB)) || (cmpLt && sumOut[31]);

  always_comb begin
    case (aluOp)
      cpuPkg::AluLogic: begin
        result = logicInvert ? ~logicRaw : logicRaw;
      end
      cpuPkg::AluArith: begin
        result = sumOut;
      end
      cpuPkg::AluCompare: begin
        result = {31'd0, cmpRaw ^ cmpInvert};
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

/* logic/executeStage.sv */
`timescale 1ns/1ps

module executeStage (
  input  logic              CLK,
  input  logic              reset,
  decodeIf.execute          ctrl,
  input  cpuPkg::wordT      fetchPc,
  input  cpuPkg::wordT      readData1,
  input  cpuPkg::wordT      readData2,
  output cpuPkg::wordT      aluResult,
  output cpuPkg::wordT      storeData,
  output cpuPkg::stageCtrlT stageCtrl,
  output cpuPkg::wordT      linkPc,
  output logic              takeRedirect,
  output cpuPkg::wordT      redirectPc
);

  cpuPkg::aluOpT aluOpQ;
  cpuPkg::logicOpT logicOpQ;
  logic logicInvertQ, subtractQ, cmpEqQ, cmpLtQ, cmpInvertQ;
  logic useImmQ, zeroImmQ, isBranchQ, isJumpQ;
  cpuPkg::wordT immQ, data1Q, data2Q, pcPlus4Q, operandB;
  cpuPkg::stageCtrlT stageNext;

  // Pack the bits that M and W still need
  always_comb begin
    stageNext = '0;
    stageNext[cpuPkg::StageMemWrite] = ctrl.memWrite;
    stageNext[cpuPkg::StageMemRead] = ctrl.memRead;
    stageNext[cpuPkg::StageRegWrite] = ctrl.regWrite;
    stageNext[cpuPkg::StageSavePc] = ctrl.savePc;
    stageNext[cpuPkg::StageDestLsb +: cpuPkg::RegNumWidth] = ctrl.destReg;
  end

  // R to A control register
  always_ff @(posedge CLK) begin
    if (reset) begin
      aluOpQ <= cpuPkg::AluLogic;
      logicOpQ <= cpuPkg::LogicAnd;
      {logicInvertQ, subtractQ, cmpEqQ, cmpLtQ, cmpInvertQ} <= '0;
      {useImmQ, zeroImmQ, isBranchQ, isJumpQ} <= '0;
      stageCtrl <= '0;
    end else begin
      aluOpQ <= ctrl.aluOp;
      logicOpQ <= ctrl.logicOp;
      {logicInvertQ, subtractQ, cmpEqQ, cmpLtQ, cmpInvertQ} <=
        {ctrl.logicInvert, ctrl.subtract, ctrl.cmpEq, ctrl.cmpLt, ctrl.cmpInvert};
      {useImmQ, zeroImmQ, isBranchQ, isJumpQ} <=
        {ctrl.useImm, ctrl.zeroImm, ctrl.isBranch, ctrl.isJump};
      stageCtrl <= stageNext;
    end
  end

  // Operands and the instruction's own PC+4
  always_ff @(posedge CLK) begin
    immQ <= ctrl.immValue;
    data1Q <= readData1;
    data2Q <= readData2;
    pcPlus4Q <= fetchPc + cpuPkg::PcStep;
  end

  // Register, sign-extended immediate or zero
  assign operandB = useImmQ ? (zeroImmQ ? '0 : immQ) : data2Q;

  alu alu_i (
    .operandA    (data1Q),
    .operandB    (operandB),
    .aluOp       (aluOpQ),
    .logicOp     (logicOpQ),
    .logicInvert (logicInvertQ),
    .subtract    (subtractQ),
    .cmpEq       (cmpEqQ),
    .cmpLt       (cmpLtQ),
    .cmpInvert   (cmpInvertQ),
    .result      (aluResult)
  );

  // JRL target is rs plus offset, computed by the adder
  assign takeRedirect = isJumpQ || (isBranchQ && (aluResult != '0));
  assign redirectPc = isJumpQ ? aluResult : pcPlus4Q + immQ;

  // SW writes the second register read
  assign storeData = data2Q;
  assign linkPc = pcPlus4Q;

endmodule

/* logic/memWriteback.sv */
`timescale 1ns/1ps

module memWriteback (
  input  logic              CLK,
  input  logic              reset,
  input  cpuPkg::wordT      aluResult,
  input  cpuPkg::wordT      storeData,
  input  cpuPkg::wordT      linkPc,
  input  cpuPkg::stageCtrlT stageCtrl,
  output cpuPkg::wordT      dataAddr,
  output cpuPkg::wordT      dataWrData,
  output logic              dataWe,
  output logic              dataRe,
  input  cpuPkg::wordT      dataRdData,
  output logic              regWe,
  output cpuPkg::regNumT    regWaddr,
  output cpuPkg::wordT      regWdata
);

  cpuPkg::stageCtrlT ctrlM;
  cpuPkg::wordT aluM, storeM, linkM, nonMemW;
  logic regWriteW, memReadW;
  cpuPkg::regNumT destW;

  always_ff @(posedge CLK) begin
    if (reset) begin
      ctrlM <= '0;
      regWriteW <= 1'b0;
      memReadW <= 1'b0;
    end else begin
      ctrlM <= stageCtrl;
      regWriteW <= ctrlM[cpuPkg::StageRegWrite];
      memReadW <= ctrlM[cpuPkg::StageMemRead];
    end
  end

  always_ff @(posedge CLK) begin
    aluM <= aluResult;
    storeM <= storeData;
    linkM <= linkPc;
    // JRL saves its return address, others the ALU result
    nonMemW <= ctrlM[cpuPkg::StageSavePc] ? linkM : aluM;
    destW <= ctrlM[cpuPkg::StageDestLsb +: cpuPkg::RegNumWidth];
  end

  // Data port is driven in M
  assign dataAddr = aluM;
  assign dataWrData = storeM;
  assign dataWe = ctrlM[cpuPkg::StageMemWrite];
  assign dataRe = ctrlM[cpuPkg::StageMemRead];

  // Load data arrives one cycle later, in W
  assign regWe = regWriteW;
  assign regWaddr = destW;
  assign regWdata = memReadW ? dataRdData : nonMemW;

endmodule

/* logic/pipeCpu.sv */
`timescale 1ns/1ps

module pipeCpu (
  input  logic         CLK,
  input  logic         reset,
  output cpuPkg::wordT imemAddr,
  input  cpuPkg::wordT imemData,
  output cpuPkg::wordT dataAddr,
  output cpuPkg::wordT dataWrData,
  output logic         dataWe,
  output logic         dataRe,
  input  cpuPkg::wordT dataRdData
);

  logic issueValid, takeRedirect, regWe;
  cpuPkg::wordT redirectPc, readData1, readData2, regWdata;
  cpuPkg::wordT aluResult, storeData, linkPc;
  cpuPkg::regNumT readReg1, readReg2, regWaddr;
  cpuPkg::stageCtrlT stageCtrl;

  // Decoded control from R into A
  decodeIf ctrlBus_i ();

  fetchUnit fetch_i (
    .CLK          (CLK),
    .reset        (reset),
    .takeRedirect (takeRedirect),
    .redirectPc   (redirectPc),
    .imemAddr     (imemAddr),
    .issueValid   (issueValid)
  );

  instrDecoder decode_i (
    .instrWord  (imemData),
    .issueValid (issueValid),
    .readReg1   (readReg1),
    .readReg2   (readReg2),
    .ctrl       (ctrlBus_i.decoder)
  );

  regFile regs_i (
    .CLK       (CLK),
    .readReg1  (readReg1),
    .readReg2  (readReg2),
    .readData1 (readData1),
    .readData2 (readData2),
    .regWe     (regWe),
    .regWaddr  (regWaddr),
    .regWdata  (regWdata)
  );

  // PC is still the R-stage instruction's address when A registers it
  executeStage execute_i (
    .CLK          (CLK),
    .reset        (reset),
    .ctrl         (ctrlBus_i.execute),
    .fetchPc      (imemAddr),
    .readData1    (readData1),
    .readData2    (readData2),
    .aluResult    (aluResult),
    .storeData    (storeData),
    .stageCtrl    (stageCtrl),
    .linkPc       (linkPc),
    .takeRedirect (takeRedirect),
    .redirectPc   (redirectPc)
  );

  memWriteback memWb_i (
    .CLK        (CLK),
    .reset      (reset),
    .aluResult  (aluResult),
    .storeData  (storeData),
    .linkPc     (linkPc),
    .stageCtrl  (stageCtrl),
    .dataAddr   (dataAddr),
    .dataWrData (dataWrData),
    .dataWe     (dataWe),
    .dataRe     (dataRe),
    .dataRdData (dataRdData),
    .regWe      (regWe),
    .regWaddr   (regWaddr),
    .regWdata   (regWdata)
  );

endmodule

/* dv/tbClock.sv */
`timescale 1ns/1ps

module tbClock (
  output logic CLK,
  output logic reset,
  input  logic restart
);

  logic clkQ = 1'b0;
  logic resetQ = 1'b1;
  int heldCycles = 0;

  // 100 ns period
  always #50 clkQ = ~clkQ;

  // Reset stays high while restart is held, then two more cycles
  always @(posedge clkQ) begin
    if (restart) begin
      resetQ <= 1'b1;
      heldCycles <= 0;
    end else if (resetQ) begin
      heldCycles <= heldCycles + 1;
      if (heldCycles == 1) begin
        resetQ <= 1'b0;
      end
    end
  end

  assign CLK = clkQ;
  assign reset = resetQ;

endmodule

/* dv/pipeCpuChecker.sv */
`timescale 1ns/1ps

module pipeCpuChecker (
  input logic         CLK,
  input logic         reset,
  input cpuPkg::wordT imemAddr,
  input logic         dataWe,
  input logic         dataRe
);

  // Data port does one access per cycle
  noReadWrite: assert property (@(posedge CLK) disable iff (reset) !(dataWe && dataRe))
    else $error("dataWe and dataRe are high together");

  // Fetch addresses are whole words
  fetchAligned: assert property (@(posedge CLK) disable iff (reset) imemAddr[1:0] == 2'b00)
    else $error("imemAddr %h is not word aligned", imemAddr);

  // Reset clears the M stage control
  quietAfterReset: assert property (@(posedge CLK) reset |=> (!dataWe && !dataRe))
    else $error("data port active in the cycle after reset");

endmodule

bind pipeCpu pipeCpuChecker checker_i (
  .CLK      (CLK),
  .reset    (reset),
  .imemAddr (imemAddr),
  .dataWe   (dataWe),
  .dataRe   (dataRe)
);

/* dv/pipeCpuTb.sv */
`timescale 1ns/1ps

module pipeCpuTb;

  localparam int ImemWords = 1024;
  localparam int DmemWords = 256;
  localparam int StartIdx = int'(cpuPkg::StartPc[11:2]);
  localparam cpuPkg::wordT DataBase = 32'h0000_0100;
  localparam cpuPkg::wordT StoreBase = 32'h0000_0200;
  localparam cpuPkg::wordT DoneAddr = 32'h0000_03fc;
  // Instructions of all programs together, three cycles each plus restarts
  localparam int ProgramInstrTotal = 98;
  localparam int WatchdogCycles = ProgramInstrTotal * 3 + 150;

  logic CLK, reset, restart;
  cpuPkg::wordT imemAddr, dataAddr, dataWrData;
  cpuPkg::wordT imemData = '0;
  cpuPkg::wordT dataRdData = '0;
  logic dataWe, dataRe;

  cpuPkg::wordT imem [ImemWords];
  cpuPkg::wordT dmem [DmemWords];
  // Preload port into the data memory, used during reset
  logic loadWe;
  logic [7:0] loadIdx;
  cpuPkg::wordT loadWord;

  // Every store seen on the data port
  cpuPkg::wordT storeAddrQ[$];
  cpuPkg::wordT storeDataQ[$];
  int storeBase;

  // Program being built, its data words and the stores it should make
  cpuPkg::wordT progWords[$];
  cpuPkg::wordT preloadQ[$];
  cpuPkg::wordT expAddrQ[$];
  cpuPkg::wordT expDataQ[$];
  cpuPkg::wordT nextStoreAddr;

  int errorCount, checkCount;

  tbClock clk_i (
    .CLK     (CLK),
    .reset   (reset),
    .restart (restart)
  );

  pipeCpu dut_i (
    .CLK        (CLK),
    .reset      (reset),
    .imemAddr   (imemAddr),
    .imemData   (imemData),
    .dataAddr   (dataAddr),
    .dataWrData (dataWrData),
    .dataWe     (dataWe),
    .dataRe     (dataRe),
    .dataRdData (dataRdData)
  );

  // Instruction memory, one cycle read
  always @(posedge CLK) begin
    imemData <= imem[imemAddr[11:2]];
  end

  // Data memory, one cycle read on dataRe, logs stores
  always @(posedge CLK) begin
    if (loadWe) begin
      dmem[loadIdx] <= loadWord;
    end else if (dataWe) begin
      dmem[dataAddr[9:2]] <= dataWrData;
      storeAddrQ.push_back(dataAddr);
      storeDataQ.push_back(dataWrData);
    end
    // Read data holds between loads
    if (dataRe) begin
      dataRdData <= dmem[dataAddr[9:2]];
    end
  end

  // Unloaded words carry their own address
  initial begin
    for (int i = 0; i < DmemWords; i++) begin
      dmem[i] = 32'h5a5a_0000 ^ (i << 2);
    end
  end

  function automatic cpuPkg::wordT encReg(cpuPkg::opcodeT op, int rd, int rs, int rt);
    return {op, 4'(rd), 4'(rs), 4'(rt), 12'h000};
  endfunction

  function automatic cpuPkg::wordT encImm(cpuPkg::opcodeT op, int rd, int rs,
                                          logic [15:0] imm);
    return {op, 4'(rd), 4'(rs), imm};
  endfunction

  function automatic cpuPkg::wordT signExtend(logic [15:0] imm);
    return {{16{imm[15]}}, imm};
  endfunction

  // Kinds 0..4 are AND, NAND, OR, NOR, XOR
  function automatic cpuPkg::wordT logicRef(int kind, cpuPkg::wordT a, cpuPkg::wordT b);
    case (kind)
      0: return a & b;
      1: return ~(a & b);
      2: return a | b;
      3: return ~(a | b);
      default: return a ^ b;
    endcase
  endfunction

  // Kinds 0..5 are ADD, SUB, EQ, NE, LT, LE
  function automatic cpuPkg::wordT arithRef(int kind, cpuPkg::wordT a, cpuPkg::wordT b);
    cpuPkg::wordT diff;
    diff = a - b;
    case (kind)
      0: return a + b;
      1: return diff;
      2: return {31'd0, a == b};
      3: return {31'd0, a != b};
      4: return {31'd0, diff[31]};
      default: return {31'd0, (a == b) || diff[31]};
    endcase
  endfunction

  task automatic checkValue(string name, cpuPkg::wordT expected, cpuPkg::wordT actual);
    checkCount++;
    if (expected !== actual) begin
      errorCount++;
      $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic emit(cpuPkg::wordT word);
    progWords.push_back(word);
  endtask

  // Fresh program that first clears r0
  task automatic beginProgram();
    progWords.delete();
    preloadQ.delete();
    expAddrQ.delete();
    expDataQ.delete();
    nextStoreAddr = StoreBase;
    emit(encImm(cpuPkg::OpAndi, 0, 0, 16'h0000));
  endtask

  // SW of a register, expected on the port only when it should appear
  task automatic storeReg(int rd, cpuPkg::wordT expected, bit appears);
    emit(encImm(cpuPkg::OpSw, rd, 0, nextStoreAddr[15:0]));
    if (appears) begin
      expAddrQ.push_back(nextStoreAddr);
      expDataQ.push_back(expected);
    end
    nextStoreAddr += 4;
  endtask

  // Reset the DUT, load both memories and release
  task automatic startProgram();
    emit(encImm(cpuPkg::OpSw, 0, 0, DoneAddr[15:0]));
    @(posedge CLK);
    restart <= 1'b1;
    @(posedge CLK);
    @(posedge CLK);
    for (int i = 0; i < ImemWords; i++) begin
      imem[i] = '0;
    end
    foreach (progWords[i]) begin
      imem[StartIdx + i] = progWords[i];
    end
    foreach (preloadQ[i]) begin
      loadWe <= 1'b1;
      loadIdx <= 8'(DataBase[9:2] + i);
      loadWord <= preloadQ[i];
      @(posedge CLK);
    end
    loadWe <= 1'b0;
    restart <= 1'b0;
    storeBase = storeAddrQ.size();
    do @(negedge CLK); while (reset);
  endtask

  // Wait for the done store, then compare the logged stores
  task automatic finishProgram();
    int n;
    while (storeAddrQ.size() <= storeBase ||
           storeAddrQ[storeAddrQ.size() - 1] != DoneAddr) begin
      @(negedge CLK);
    end
    n = storeAddrQ.size() - storeBase - 1;
    checkValue("store count", 32'(expAddrQ.size()), 32'(n));
    for (int i = 0; i < expAddrQ.size() && i < n; i++) begin
      checkValue("dataAddr", expAddrQ[i], storeAddrQ[storeBase + i]);
      checkValue("dataWrData", expDataQ[i], storeDataQ[storeBase + i]);
    end
  endtask

  task automatic resetFetchTest();
    beginProgram();
    startProgram();
    checkValue("imemAddr", cpuPkg::StartPc, imemAddr);
    checkValue("dataWe", 32'd0, {31'd0, dataWe});
    // One fetch slot is three cycles
    for (int k = 1; k < 9; k++) begin
      @(negedge CLK);
      checkValue("imemAddr", cpuPkg::StartPc + cpuPkg::PcStep * (k / 3), imemAddr);
    end
    finishProgram();
  endtask

  task automatic logicTest();
    cpuPkg::opcodeT regOps [5];
    cpuPkg::opcodeT immOps [5];
    cpuPkg::wordT a, b;
    logic [15:0] imm;
    regOps = '{cpuPkg::OpAnd, cpuPkg::OpNand, cpuPkg::OpOr, cpuPkg::OpNor, cpuPkg::OpXor};
    immOps = '{cpuPkg::OpAndi, cpuPkg::OpNandi, cpuPkg::OpOri, cpuPkg::OpNori, cpuPkg::OpXori};
    a = $urandom;
    b = $urandom;
    beginProgram();
    preloadQ = '{a, b};
    emit(encImm(cpuPkg::OpLw, 1, 0, DataBase[15:0]));
    emit(encImm(cpuPkg::OpLw, 2, 0, DataBase[15:0] + 16'd4));
    for (int k = 0; k < 5; k++) begin
      emit(encReg(regOps[k], 3, 1, 2));
      storeReg(3, logicRef(k, a, b), 1'b1);
      imm = 16'($urandom);
      emit(encImm(immOps[k], 3, 1, imm));
      storeReg(3, logicRef(k, a, signExtend(imm)), 1'b1);
    end
    startProgram();
    finishProgram();
  endtask

  task automatic arithTest();
    cpuPkg::opcodeT regOps [6];
    cpuPkg::opcodeT immOps [6];
    cpuPkg::wordT a, b;
    logic [15:0] imm;
    regOps = '{cpuPkg::OpAdd, cpuPkg::OpSub, cpuPkg::OpEq, cpuPkg::OpNe, cpuPkg::OpLt,
               cpuPkg::OpLe};
    immOps = '{cpuPkg::OpAddi, cpuPkg::OpSubi, cpuPkg::OpEqi, cpuPkg::OpNei, cpuPkg::OpLti,
               cpuPkg::OpLei};
    a = $urandom;
    b = $urandom;
    beginProgram();
    preloadQ = '{a, b};
    emit(encImm(cpuPkg::OpLw, 1, 0, DataBase[15:0]));
    emit(encImm(cpuPkg::OpLw, 2, 0, DataBase[15:0] + 16'd4));
    for (int k = 0; k < 6; k++) begin
      emit(encReg(regOps[k], 3, 1, 2));
      storeReg(3, arithRef(k, a, b), 1'b1);
      imm = 16'($urandom);
      emit(encImm(immOps[k], 3, 1, imm));
      storeReg(3, arithRef(k, a, signExtend(imm)), 1'b1);
    end
    // Equal operands for EQ, LT and LE
    for (int k = 2; k < 6; k += 2) begin
      emit(encReg(regOps[k], 3, 1, 1));
      storeReg(3, arithRef(k, a, a), 1'b1);
    end
    emit(encReg(cpuPkg::OpLe, 3, 1, 1));
    storeReg(3, arithRef(5, a, a), 1'b1);
    startProgram();
    finishProgram();
  endtask

  // Offset one skips the marker store right after the branch
  task automatic branchCase(cpuPkg::wordT instr, bit taken, cpuPkg::wordT a, cpuPkg::wordT b);
    emit(instr);
    storeReg(1, a, !taken);
    storeReg(3, b, 1'b1);
  endtask

  task automatic branchTest();
    cpuPkg::wordT a, b;
    a = $urandom | 32'd1;
    b = a ^ 32'h0000_0100;
    beginProgram();
    preloadQ = '{a, b};
    // r1 and r2 equal and nonzero, r3 differs
    emit(encImm(cpuPkg::OpLw, 1, 0, DataBase[15:0]));
    emit(encImm(cpuPkg::OpLw, 2, 0, DataBase[15:0]));
    emit(encImm(cpuPkg::OpLw, 3, 0, DataBase[15:0] + 16'd4));
    branchCase(encImm(cpuPkg::OpBeq, 2, 1, 16'd1), 1'b1, a, b);
    branchCase(encImm(cpuPkg::OpBeq, 3, 1, 16'd1), 1'b0, a, b);
    branchCase(encImm(cpuPkg::OpBne, 3, 1, 16'd1), 1'b1, a, b);
    branchCase(encImm(cpuPkg::OpBne, 2, 1, 16'd1), 1'b0, a, b);
    branchCase(encImm(cpuPkg::OpBeqz, 0, 0, 16'd1), 1'b1, a, b);
    branchCase(encImm(cpuPkg::OpBeqz, 1, 0, 16'd1), 1'b0, a, b);
    branchCase(encImm(cpuPkg::OpBnez, 1, 0, 16'd1), 1'b1, a, b);
    branchCase(encImm(cpuPkg::OpBnez, 0, 0, 16'd1), 1'b0, a, b);
    startProgram();
    finishProgram();
  endtask

  task automatic jumpTest();
    cpuPkg::wordT jrlPc;
    beginProgram();
    // r6 points at the JRL itself, so the target is two words on
    jrlPc = cpuPkg::StartPc + cpuPkg::PcStep * (progWords.size() + 1);
    emit(encImm(cpuPkg::OpAddi, 6, 0, jrlPc[15:0]));
    emit(encImm(cpuPkg::OpJrl, 5, 6, 16'd2));
    storeReg(5, '0, 1'b0);
    storeReg(5, jrlPc + cpuPkg::PcStep, 1'b1);
    // All-zero word, registers must hold
    emit('0);
    storeReg(5, jrlPc + cpuPkg::PcStep, 1'b1);
    storeReg(6, jrlPc, 1'b1);
    startProgram();
    finishProgram();
  endtask

  initial begin
    restart = 1'b0;
    loadWe = 1'b0;
    loadIdx = '0;
    loadWord = '0;
    errorCount = 0;
    checkCount = 0;
    void'($urandom(2531));
    resetFetchTest();
    logicTest();
    arithTest();
    branchTest();
    jumpTest();
    $display("Checks %0d, errors %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Ends a hung run
  initial begin
    repeat (WatchdogCycles) @(posedge CLK);
    $display("Timeout: the tests did not finish within %0d cycles", WatchdogCycles);
    $display("Finished with errors");
    $finish;
  end

endmodule

/* filelist.f */
logic/cpuPkg.sv
logic/decodeIf.sv
logic/fetchUnit.sv
logic/instrDecoder.sv
logic/regFile.sv
logic/alu.sv
logic/executeStage.sv
logic/memWriteback.sv
logic/pipeCpu.sv
dv/tbClock.sv
dv/pipeCpuChecker.sv
dv/pipeCpuTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module pipeCpuTb \
  -Mdir obj_dir -o simPipeCpu

status=0
./obj_dir/simPipeCpu > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Finished with errors" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi
echo "Simulation passed"
